// File: Makefile
TOP = coeff_mpram_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/coeff_mpram_tb.sv
/*
 * Testbench for the receiver coefficient register file: APB driver,
 * typed compare tasks and replay of the test data file
 */
`timescale 1ns/1ps
`default_nettype none

module coeff_mpram_tb
    import rx_cfg_pkg::*;
;

    localparam int ready_timeout = 8;
    localparam int valid_timeout = 8;

    logic                 clk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    apb_addr_t            paddr;
    apb_data_t            pwdata;
    logic                 pready;
    apb_data_t            prdata;
    coeff_t               fd_coeffs    [fd_taps];
    coeff_t               iir24_coeffs [iir_coeffs];
    coeff_t               iir1_coeffs  [iir_coeffs];
    coeff_t               iir2_coeffs  [iir_coeffs];
    logic                 fd_valid;
    logic                 iir24_valid;
    logic                 iir1_valid;
    logic                 iir2_valid;
    cic_r_t               cic_r;
    logic [ctrl_bits-1:0] ctrl;
    logic [1:0]           out_sel;
    logic [2:0]           coeff_sel;
    logic [2:0]           status;

    // Outputs saved around writes to unmapped addresses
    coeff_t      fd_snap    [fd_taps];
    coeff_t      iir24_snap [iir_coeffs];
    coeff_t      iir1_snap  [iir_coeffs];
    coeff_t      iir2_snap  [iir_coeffs];
    logic [17:0] cfg_snap;
    integer      seed;

    coeff_mpram UUT (
        .clk (clk), .rst_n (rst_n), .psel (psel), .penable (penable),
        .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata),
        .pready (pready), .prdata (prdata),
        .fd_coeffs (fd_coeffs), .fd_valid (fd_valid),
        .iir24_coeffs (iir24_coeffs), .iir24_valid (iir24_valid),
        .iir1_coeffs (iir1_coeffs), .iir1_valid (iir1_valid),
        .iir2_coeffs (iir2_coeffs), .iir2_valid (iir2_valid),
        .cic_r (cic_r), .ctrl (ctrl), .out_sel (out_sel),
        .coeff_sel (coeff_sel), .status (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input apb_data_t got, input apb_data_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_coeff(input coeff_t got, input coeff_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cic(input cic_r_t got, input cic_r_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [3:0] valid_vec();
        return {iir2_valid, iir1_valid, iir24_valid, fd_valid};
    endfunction

    function automatic logic [17:0] cfg_fields();
        return {cic_r, ctrl, out_sel, coeff_sel, status};
    endfunction

    // Only the last index of each bank raises its valid
    function automatic logic [3:0] expected_valid(input apb_addr_t addr);
        if (addr == iir24_base - 1) return 4'b0001;
        if (addr == iir1_base - 1) return 4'b0010;
        if (addr == iir2_base - 1) return 4'b0100;
        if (addr == cic_addr - 1) return 4'b1000;
        return 4'b0000;
    endfunction

    ////////////////////////////////////////
    // APB driver and waits
    ////////////////////////////////////////
    task automatic apb_transfer(input logic wr, input apb_addr_t addr,
                                input apb_data_t data, output apb_data_t rdata);
        int cycles;
        check_pulse(pready, 1'b0, "pready before setup");
        psel    = 1'b1;   // Setup cycle
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 0;
        while (pready !== 1'b1) begin
            if (cycles == ready_timeout) begin
                $display("Timeout: pready stayed low for %0d access cycles", ready_timeout);
                abort_run();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        check_word(apb_data_t'(cycles), '0, "wait states before pready");
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        check_pulse(pready, 1'b0, "pready after the access cycle");
        check_word(prdata, '0, "prdata outside an access cycle");
    endtask

    task automatic wait_valid(input logic [3:0] mask);
        int cycles;
        cycles = 0;
        while ((valid_vec() & mask) == 4'b0000) begin
            if (cycles == valid_timeout) begin
                $display("Timeout: no valid pulse within %0d cycles of the write", valid_timeout);
                abort_run();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        check_word(apb_data_t'(cycles), '0, "cycles from commit to valid");
    endtask

    task automatic take_snapshot();
        fd_snap    = fd_coeffs;
        iir24_snap = iir24_coeffs;
        iir1_snap  = iir1_coeffs;
        iir2_snap  = iir2_coeffs;
        cfg_snap   = cfg_fields();
    endtask

    task automatic compare_snapshot();
        for (int i = 0; i < fd_taps; i++) begin
            check_coeff(fd_coeffs[i], fd_snap[i], "fd_coeffs after unmapped write");
        end
        for (int i = 0; i < iir_coeffs; i++) begin
            check_coeff(iir24_coeffs[i], iir24_snap[i], "iir24_coeffs after unmapped write");
            check_coeff(iir1_coeffs[i], iir1_snap[i], "iir1_coeffs after unmapped write");
            check_coeff(iir2_coeffs[i], iir2_snap[i], "iir2_coeffs after unmapped write");
        end
        check_word(apb_data_t'(cfg_fields()), apb_data_t'(cfg_snap),
                   "control fields after unmapped write");
    endtask

    // Output that a read address maps onto must hold the read value
    task automatic check_output(input apb_addr_t addr, input apb_data_t exp);
        apb_addr_t off;
        if (addr < iir24_base) begin
            check_coeff(fd_coeffs[addr], exp[coeff_w-1:0], "fd_coeffs entry");
        end else if (addr < iir1_base) begin
            off = addr - iir24_base;
            check_coeff(iir24_coeffs[off[2:0]], exp[coeff_w-1:0], "iir24_coeffs entry");
        end else if (addr < iir2_base) begin
            off = addr - iir1_base;
            check_coeff(iir1_coeffs[off[2:0]], exp[coeff_w-1:0], "iir1_coeffs entry");
        end else if (addr < cic_addr) begin
            off = addr - iir2_base;
            check_coeff(iir2_coeffs[off[2:0]], exp[coeff_w-1:0], "iir2_coeffs entry");
        end else if (addr == cic_addr) begin
            check_cic(cic_r, exp[4:0], "cic_r output");
        end else if (addr < out_sel_addr) begin
            off = addr - ctrl_base;
            check_pulse(ctrl[off[2:0]], exp[0], "ctrl bit output");
        end else if (addr == out_sel_addr) begin
            check_word(apb_data_t'(out_sel), exp, "out_sel output");
        end else if (addr == coeff_sel_addr) begin
            check_word(apb_data_t'(coeff_sel), exp, "coeff_sel output");
        end else if (addr == status_addr) begin
            check_word(apb_data_t'(status), exp, "status output");
        end
    endtask

    task automatic check_reset_state();
        check_pulse(pready, 1'b0, "pready after reset");
        check_word(prdata, '0, "prdata after reset");
        check_word(apb_data_t'(valid_vec()), '0, "valid pulses after reset");
        check_cic(cic_r, 5'd1, "cic_r after reset");
        check_word(apb_data_t'({ctrl, out_sel, coeff_sel, status}), '0,
                   "ctrl and selects after reset");
    endtask

    ////////////////////////////////////////
    // Replay of the test data file
    ////////////////////////////////////////
    initial begin
        int         fd;
        int         code;
        int         gap;
        logic [7:0] op;
        apb_addr_t  addr;
        apb_data_t  wdata;
        apb_data_t  expected;
        apb_data_t  rdata;
        logic [3:0] exp_valid;
        string      rest;

        seed    = 49739;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();

        fd = $fopen("bench/coeff_mpram_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/coeff_mpram_testdata.txt for reading");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            if (op == "#") begin
                code = $fgets(rest, fd);   // Comment line
                continue;
            end
            code = $fscanf(fd, " %h %h %h", addr, wdata, expected);
            if (code != 3) begin
                $display("Test data line has fewer than four columns");
                abort_run();
            end
            if (op == "W") begin
                exp_valid = expected_valid(addr);
                if (addr > status_addr) take_snapshot();
                apb_transfer(1'b1, addr, wdata, rdata);
                if (exp_valid != 4'b0000) wait_valid(exp_valid);
                check_word(apb_data_t'(valid_vec()), apb_data_t'(exp_valid),
                           $sformatf("valid pulses after write to %0d", addr));
                @(posedge clk);
                #1;
                check_word(apb_data_t'(valid_vec()), '0, "valid pulses one cycle later");
                if (addr > status_addr) compare_snapshot();
            end else if (op == "R") begin
                apb_transfer(1'b0, addr, '0, rdata);
                check_word(rdata, expected, $sformatf("read of address %0d", addr));
                check_output(addr, expected);
            end else begin
                $display("Unknown operation in the test data file");
                abort_run();
            end
            gap = $random(seed) & 3;   // 0 to 3 idle cycles
            repeat (gap) begin
                @(posedge clk);
                #1;
                check_pulse(pready, 1'b0, "pready while idle");
            end
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/coeff_mpram_testdata.txt
# Columns: op (W write, R read), address, write data, expected read word, all hex
# Write lines carry 00000000 in the expected column
# Reset defaults
R 00 00000000 FFFFFF76
R 23 00000000 00022D87
R 47 00000000 FFFFFF76
R 49 00000000 0005907C
R 4E 00000000 FFFC8F9F
R 57 00000000 00000001
R 58 00000000 00000000
R 5E 00000000 00000000
# Decimator and notch banks
W 05 000FFFFE 00000000
R 05 00000000 FFFFFFFE
W 47 12345678 00000000
R 47 00000000 00045678
W 4C 00080000 00000000
R 4C 00000000 FFF80000
R 4D 00000000 00037061
R 52 00000000 00037061
W 51 000C0001 00000000
W 56 00000123 00000000
R 51 00000000 FFFC0001
R 56 00000000 00000123
# Configuration fields
W 57 FFFFFFE8 00000000
R 57 00000000 00000008
W 59 00000003 00000000
R 59 00000000 00000001
W 5D 0000000E 00000000
R 5D 00000000 00000002
W 5F 00000007 00000000
R 5F 00000000 00000007
# Unmapped addresses
W 60 12345678 00000000
W 7F FFFFFFFF 00000000
R 60 00000000 AAAAAAAA
R 7F 00000000 AAAAAAAA

// File: design/apb_access.sv
/*
 * APB slave phase tracking: registered ready, read-data
 * capture and the write strobe for the register file
 */
`timescale 1ns/1ps
`default_nettype none

module apb_access
    import rx_cfg_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_data_t rd_word,
    output logic           pready,
    output apb_data_t      prdata,
    output logic           wr_en
);

    logic setup;
    logic rd_capture;

    assign setup      = psel && !penable;
    assign rd_capture = setup && !pwrite;

    // Commit happens at the edge closing the access cycle
    assign wr_en = psel && penable && pwrite && pready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready <= 1'b0;
            prdata <= '0;
        end else begin
            pready <= setup;   // No wait states
            if (rd_capture) begin
                prdata <= rd_word;
            end else begin
                prdata <= '0;  // Only driven during a read access
            end
        end
    end

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////
    a_ready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable)
    ) else $error("pready outside an access cycle");

    a_ready_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        pready |=> !pready
    ) else $error("pready held for two cycles");

endmodule

`default_nettype wire

// File: design/coeff_bank.sv
/*
 * Coefficient bank with reset defaults, indexed writes and
 * a one-cycle valid pulse after the last entry is written
 */
`timescale 1ns/1ps
`default_nettype none

module coeff_bank
    import rx_cfg_pkg::*;
#(
    parameter int     DEPTH = iir_coeffs,
    parameter coeff_t RESET_VALS [DEPTH] = '{default: '0}
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      wr_en,
    input  wire logic      bank_sel,
    input  wire apb_addr_t idx,
    input  wire coeff_t    wdata,
    output coeff_t         coeffs [DEPTH],
    output logic           valid
);

    logic wr_bank;

    assign wr_bank = wr_en && bank_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coeffs <= RESET_VALS;
        end else if (wr_bank) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (idx == apb_addr_t'(i)) begin
                    coeffs[i] <= wdata;
                end
            end
        end
    end

    // Downstream filter reloads its taps on this pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= wr_bank && (idx == apb_addr_t'(DEPTH - 1));
        end
    end

    // Writes are at least two cycles apart on APB
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |=> !valid
    ) else $error("bank valid longer than one cycle");

endmodule

`default_nettype wire

// File: design/coeff_mpram.sv
/*
 * Receiver coefficient register file top: APB slave, decimator
 * bank, three notch banks, chain control registers and decode
 */
`timescale 1ns/1ps
`default_nettype none

module coeff_mpram
    import rx_cfg_pkg::*;
    import rx_coeff_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output logic           pready,
    output apb_data_t      prdata,
    output coeff_t         fd_coeffs    [fd_taps],
    output logic           fd_valid,
    output coeff_t         iir24_coeffs [iir_coeffs],
    output logic           iir24_valid,
    output coeff_t         iir1_coeffs  [iir_coeffs],
    output logic           iir1_valid,
    output coeff_t         iir2_coeffs  [iir_coeffs],
    output logic           iir2_valid,
    output cic_r_t         cic_r,
    output logic [ctrl_bits-1:0] ctrl,
    output logic [1:0]     out_sel,
    output logic [2:0]     coeff_sel,
    output logic [2:0]     status
);

    logic      wr_en;
    region_t   region;
    apb_addr_t idx;
    apb_data_t rd_word;
    coeff_t    coeff_wdata;

    assign coeff_wdata = pwdata[coeff_w-1:0];   // Upper bits ignored

    apb_access u_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .rd_word (rd_word),
        .pready  (pready),
        .prdata  (prdata),
        .wr_en   (wr_en)
    );

    region_decode u_decode (
        .paddr        (paddr),
        .fd_coeffs    (fd_coeffs),
        .iir24_coeffs (iir24_coeffs),
        .iir1_coeffs  (iir1_coeffs),
        .iir2_coeffs  (iir2_coeffs),
        .cic_r        (cic_r),
        .ctrl         (ctrl),
        .out_sel      (out_sel),
        .coeff_sel    (coeff_sel),
        .status       (status),
        .region       (region),
        .idx          (idx),
        .rd_word      (rd_word)
    );

    ////////////////////////////////////////
    // Coefficient banks
    ////////////////////////////////////////
    coeff_bank #(.DEPTH(fd_taps), .RESET_VALS(fd_default)) u_fd_bank (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .bank_sel (region == FD),
        .idx (idx), .wdata (coeff_wdata), .coeffs (fd_coeffs), .valid (fd_valid)
    );

    // 2.4 MHz notch
    coeff_bank #(.DEPTH(iir_coeffs), .RESET_VALS(iir24_default)) u_iir24_bank (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .bank_sel (region == IIR24),
        .idx (idx), .wdata (coeff_wdata), .coeffs (iir24_coeffs), .valid (iir24_valid)
    );

    coeff_bank #(.DEPTH(iir_coeffs), .RESET_VALS(iir1_default)) u_iir1_bank (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .bank_sel (region == IIR1),
        .idx (idx), .wdata (coeff_wdata), .coeffs (iir1_coeffs), .valid (iir1_valid)
    );

    coeff_bank #(.DEPTH(iir_coeffs), .RESET_VALS(iir2_default)) u_iir2_bank (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .bank_sel (region == IIR2),
        .idx (idx), .wdata (coeff_wdata), .coeffs (iir2_coeffs), .valid (iir2_valid)
    );

    config_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .region    (region),
        .idx       (idx),
        .wdata     (pwdata),
        .cic_r     (cic_r),
        .ctrl      (ctrl),
        .out_sel   (out_sel),
        .coeff_sel (coeff_sel),
        .status    (status)
    );

endmodule

`default_nettype wire

// File: design/config_regs.sv
/*
 * Filter chain control: CIC decimation factor, block on/off
 * bits, output select, coefficient select and status select
 */
`timescale 1ns/1ps
`default_nettype none

module config_regs
    import rx_cfg_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      wr_en,
    input  wire region_t   region,
    input  wire apb_addr_t idx,
    input  wire apb_data_t wdata,
    output cic_r_t         cic_r,
    output logic [ctrl_bits-1:0] ctrl,
    output logic [1:0]     out_sel,
    output logic [2:0]     coeff_sel,
    output logic [2:0]     status
);

    // ctrl bit order
    //   0 fractional decimator, 1 notch 2.4 MHz, 2 notch 1/2 MHz,
    //   3 CIC, 4 FIR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cic_r     <= 5'd1;   // Pass-through decimation
            ctrl      <= '0;
            out_sel   <= '0;
            coeff_sel <= '0;
            status    <= '0;
        end else if (wr_en) begin
            case (region)
                CIC: begin
                    cic_r <= wdata[$bits(cic_r_t)-1:0];
                end
                CTRL: begin
                    for (int i = 0; i < ctrl_bits; i++) begin
                        if (idx == apb_addr_t'(i)) begin
                            ctrl[i] <= wdata[0];
                        end
                    end
                end
                OUT_SEL:   out_sel   <= wdata[1:0];
                COEFF_SEL: coeff_sel <= wdata[2:0];
                STATUS:    status    <= wdata[2:0];
                default: ;   // Coefficient and unmapped writes
            endcase
        end
    end

    // A zero factor would stall the CIC
    a_cic_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en && region == CIC) |-> (wdata[$bits(cic_r_t)-1:0] != '0)
    ) else $error("CIC decimation factor written to zero");

endmodule

`default_nettype wire

// File: design/region_decode.sv
/*
 * Address decode into region and local offset, plus the
 * read-back multiplexer over all stored values
 */
`timescale 1ns/1ps
`default_nettype none

module region_decode
    import rx_cfg_pkg::*;
(
    input  wire apb_addr_t paddr,
    input  wire coeff_t    fd_coeffs    [fd_taps],
    input  wire coeff_t    iir24_coeffs [iir_coeffs],
    input  wire coeff_t    iir1_coeffs  [iir_coeffs],
    input  wire coeff_t    iir2_coeffs  [iir_coeffs],
    input  wire cic_r_t    cic_r,
    input  wire logic [ctrl_bits-1:0] ctrl,
    input  wire logic [1:0] out_sel,
    input  wire logic [2:0] coeff_sel,
    input  wire logic [2:0] status,
    output region_t        region,
    output apb_addr_t      idx,
    output apb_data_t      rd_word
);

    logic [2:0] sub_idx;   // Offset inside a 5-entry bank or ctrl

    function automatic apb_data_t sext(input coeff_t c);
        return {{(data_w - coeff_w){c[coeff_w-1]}}, c};
    endfunction

    always_comb begin
        region = NONE;
        idx    = '0;
        if (paddr < iir24_base) begin
            region = FD;
            idx    = paddr - fd_base;
        end else if (paddr < iir1_base) begin
            region = IIR24;
            idx    = paddr - iir24_base;
        end else if (paddr < iir2_base) begin
            region = IIR1;
            idx    = paddr - iir1_base;
        end else if (paddr < cic_addr) begin
            region = IIR2;
            idx    = paddr - iir2_base;
        end else if (paddr == cic_addr) begin
            region = CIC;
        end else if (paddr < out_sel_addr) begin
            region = CTRL;
            idx    = paddr - ctrl_base;
        end else if (paddr == out_sel_addr) begin
            region = OUT_SEL;
        end else if (paddr == coeff_sel_addr) begin
            region = COEFF_SEL;
        end else if (paddr == status_addr) begin
            region = STATUS;
        end
    end

    assign sub_idx = idx[2:0];

    ////////////////////////////////////////
    // Read-back
    ////////////////////////////////////////
    always_comb begin
        case (region)
            FD:        rd_word = sext(fd_coeffs[idx]);
            IIR24:     rd_word = sext(iir24_coeffs[sub_idx]);
            IIR1:      rd_word = sext(iir1_coeffs[sub_idx]);
            IIR2:      rd_word = sext(iir2_coeffs[sub_idx]);
            CIC:       rd_word = apb_data_t'(cic_r);
            CTRL:      rd_word = apb_data_t'(ctrl[sub_idx]);   // Bit 0 only
            OUT_SEL:   rd_word = apb_data_t'(out_sel);
            COEFF_SEL: rd_word = apb_data_t'(coeff_sel);
            STATUS:    rd_word = apb_data_t'(status);
            default:   rd_word = unmapped_pattern;
        endcase
    end

endmodule

`default_nettype wire

// File: design/rx_cfg_pkg.sv
/*
 * Register file widths, APB address map and shared types
 * for the receiver coefficient and configuration block
 */
`default_nettype none

package rx_cfg_pkg;

    localparam int addr_w     = 7;
    localparam int data_w     = 32;
    localparam int coeff_w    = 20;   // S20.18 coefficients
    localparam int fd_taps    = 72;
    localparam int iir_coeffs = 5;    // b0, b1, b2, a1, a2
    localparam int ctrl_bits  = 5;

    typedef logic        [addr_w-1:0]  apb_addr_t;
    typedef logic        [data_w-1:0]  apb_data_t;
    typedef logic signed [coeff_w-1:0] coeff_t;
    typedef logic        [4:0]         cic_r_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam apb_addr_t fd_base        = 7'd0;
    localparam apb_addr_t iir24_base     = 7'd72;
    localparam apb_addr_t iir1_base      = 7'd77;
    localparam apb_addr_t iir2_base      = 7'd82;
    localparam apb_addr_t cic_addr       = 7'd87;
    localparam apb_addr_t ctrl_base      = 7'd88;   // Five on/off bits, one per word
    localparam apb_addr_t out_sel_addr   = 7'd93;
    localparam apb_addr_t coeff_sel_addr = 7'd94;
    localparam apb_addr_t status_addr    = 7'd95;

    // Read-back of 96..127
    localparam apb_data_t unmapped_pattern = 32'hAAAA_AAAA;

    typedef enum logic [3:0] {
        FD,
        IIR24,
        IIR1,
        IIR2,
        CIC,
        CTRL,
        OUT_SEL,
        COEFF_SEL,
        STATUS,
        NONE
    } region_t;

endpackage

`default_nettype wire

// File: design/rx_coeff_pkg.sv
/*
 * Reset defaults for the fractional decimator and the three
 * IIR notch banks, all in S20.18
 */
`default_nettype none

package rx_coeff_pkg;

    import rx_cfg_pkg::*;

    typedef coeff_t fd_half_t  [fd_taps/2];
    typedef coeff_t fd_table_t [fd_taps];
    typedef coeff_t iir_table_t[iir_coeffs];

    // First half of the symmetric decimator response
    localparam fd_half_t fd_half = '{
        20'shfff76, 20'shffcac, 20'shffada, 20'shfff7d,
        20'sh00309, 20'shffe7b, 20'shffe50, 20'sh00341,
        20'shffede, 20'shffd19, 20'sh0044f, 20'shfff5e,
        20'shffb2b, 20'sh005a7, 20'sh0006b, 20'shff873,
        20'sh0071e, 20'sh00246, 20'shff4c4, 20'sh00898,
        20'sh0054b, 20'shfefcc, 20'sh00a01, 20'sh00a1c,
        20'shfe8d4, 20'sh00b42, 20'sh01214, 20'shfde19,
        20'sh00c46, 20'sh02101, 20'shfc9d4, 20'sh00cfe,
        20'sh047c8, 20'shf8a18, 20'sh00d5d, 20'sh22d87   // Centre tap
    };

    // Linear phase, so the upper half mirrors the lower one
    function automatic fd_table_t mirror_fd(input fd_half_t half);
        fd_table_t full;
        for (int i = 0; i < fd_taps / 2; i++) begin
            full[i]               = half[i];
            full[fd_taps - 1 - i] = half[i];
        end
        return full;
    endfunction

    localparam fd_table_t fd_default = mirror_fd(fd_half);

    ////////////////////////////////////////
    // Notch banks, order b0 b1 b2 a1 a2
    ////////////////////////////////////////
    localparam iir_table_t iir24_default = '{
        20'sh37061, 20'sh5907c, 20'sh37061, 20'sh5907c, 20'sh2e0c3
    };

    localparam iir_table_t iir1_default = '{
        20'sh37061, 20'shc8f9f, 20'sh37061, 20'shc8f9f, 20'sh2e0c3
    };

    localparam iir_table_t iir2_default = '{
        20'sh37061, 20'sh37061, 20'sh37061, 20'sh37061, 20'sh2e0c3
    };

endpackage

`default_nettype wire

// File: list.f
design/rx_cfg_pkg.sv
design/rx_coeff_pkg.sv
design/apb_access.sv
design/coeff_bank.sv
design/config_regs.sv
design/region_decode.sv
design/coeff_mpram.sv
bench/coeff_mpram_tb.sv
